/* src.f */
+incdir+common
common/mem_pkg.sv
common/biu_if.sv
ccu/ccu_arbiter.sv
biu/wb_biu.sv
verilog/mem_subsys_top.sv
verif/wb_mem_model.sv
verif/tb_mem_subsys.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_mem_subsys
FILELIST   := src.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := SOME TESTS FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_mem_subsys.sv */
// Testbench for the memory subsystem
// Random IC and DC line requests against a Wishbone memory model and a reference line store

`default_nettype none

module tb_mem_subsys;

    import mem_pkg::*;

    localparam int    CLK_HALF        = 50;
    localparam int    DRV_DLY         = 10;
    localparam int    RST_CYCLES      = 3;
    localparam int    SEED            = 78570;
    localparam int    NUM_IC          = 12;
    localparam int    NUM_DC          = 16;
    localparam int    POOL_LINES      = 8;
    localparam addr_t POOL_BASE       = 32'h4A5C_0000;
    localparam addr_t POOL_STRIDE     = 32'h0101_0020;
    localparam int    MAX_STALL       = 3;
    localparam int    MAX_ACK_WAIT    = 3;
    localparam int    WORD_W          = $bits(wb_word_t);
    localparam int    WATCHDOG_CYCLES =
        (NUM_IC + NUM_DC) * BEATS * (MAX_STALL + MAX_ACK_WAIT + 2) * 2;

    logic clk;
    logic rst;
    logic ic_en;
    addr_t ic_addr;
    line_t ic_rdata;
    logic ic_done;
    logic dc_en;
    logic dc_we;
    addr_t dc_addr;
    line_t dc_wdata;
    line_t dc_rdata;
    logic dc_done;
    logic wb_ack;
    logic wb_stall;
    wb_word_t wb_rdata;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [WB_WORD_BYTES-1:0] wb_sel;
    addr_t wb_addr;
    wb_word_t wb_wdata;

    // Reference line store and bus monitor state
    line_t       ref_mem [addr_t];
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          rr_cnt = 0;
    logic        in_xfer = 1'b0;
    int          beat_cnt = 0;
    addr_t       xfer_base = '0;
    logic        xfer_we = 1'b0;
    line_t       xfer_line = '0;
    logic        prev_ic_done = 1'b0;
    logic        prev_dc_done = 1'b0;
    logic        contended = 1'b0;
    ccu_owner_e  last_owner = NONE;

    mem_subsys_top u_mem_subsys_top (
        .i_wb_clk (clk), .i_wb_rst (rst),
        .i_ic_en (ic_en), .i_ic_addr (ic_addr), .o_ic_data (ic_rdata), .o_ic_done (ic_done),
        .i_dc_en (dc_en), .i_dc_we (dc_we), .i_dc_addr (dc_addr), .i_dc_data (dc_wdata),
        .o_dc_data (dc_rdata), .o_dc_done (dc_done),
        .i_wb_ack (wb_ack), .i_wb_stall (wb_stall), .i_wb_data (wb_rdata),
        .o_wb_cyc (wb_cyc), .o_wb_stb (wb_stb), .o_wb_we (wb_we), .o_wb_sel (wb_sel),
        .o_wb_addr (wb_addr), .o_wb_data (wb_wdata)
    );

    wb_mem_model #(.MAX_STALL(MAX_STALL), .MAX_ACK_WAIT(MAX_ACK_WAIT), .DRV_DLY(DRV_DLY))
    u_wb_mem_model (
        .i_wb_clk (clk), .i_wb_rst (rst), .i_wb_cyc (wb_cyc), .i_wb_stb (wb_stb),
        .i_wb_we (wb_we), .i_wb_addr (wb_addr), .i_wb_data (wb_wdata),
        .o_wb_ack (wb_ack), .o_wb_stall (wb_stall), .o_wb_data (wb_rdata)
    );

    always #CLK_HALF clk = ~clk;

    task automatic check_val(input string name, input line_t exp, input line_t got);
        check_cnt++;
        assert (exp === got) else begin
            err_cnt++;
            $display("[FAIL] %s expected %0h actual %0h", name, exp, got);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        check_cnt++;
        assert (cond === 1'b1) else begin
            err_cnt++;
            $display("Error at %0t: %s", $time, what);
        end
    endtask

    function automatic addr_t pick_line_addr();
        return POOL_BASE + addr_t'($urandom % POOL_LINES) * POOL_STRIDE;
    endfunction

    // Short gaps with half of them zero so that requests meet at a release
    function automatic int pick_gap();
        return ($urandom % 2 == 0) ? 0 : int'($urandom % 4);
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int i = 0; i < $bits(line_t) / 32; i++) begin
            l[i*32 +: 32] = $urandom;
        end
        return l;
    endfunction

    // Memory never written holds a pattern of each word address
    function automatic line_t expected_line(input addr_t a);
        line_t l;
        addr_t w;
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        for (int k = 0; k < BEATS; k++) begin
            w = a + addr_t'(k * WB_WORD_BYTES);
            l[k*WORD_W +: WORD_W] = w[15:0] ^ w[31:16] ^ 16'hC3A5;
        end
        return l;
    endfunction

    task automatic note_done(input ccu_owner_e who, input logic en);
        check_true(en, "a done output rose while its enable was low");
        if (contended) begin
            rr_cnt++;
            check_true(who != last_owner, "contended grant went to the requester served last");
        end
        contended = 1'b0;
        last_owner = who;
    endtask

    // Beat and done monitor sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (wb_stb && !wb_stall) begin
                if (!in_xfer) begin
                    in_xfer = 1'b1;
                    beat_cnt = 0;
                    xfer_base = wb_addr;
                    xfer_we = wb_we;
                end
                check_true(wb_cyc && (wb_sel == '1),
                           "beat without o_wb_cyc or with partial o_wb_sel");
                check_val("o_wb_addr", line_t'(xfer_base + addr_t'(beat_cnt * WB_WORD_BYTES)),
                          line_t'(wb_addr));
                check_val("o_wb_we", line_t'(xfer_we), line_t'(wb_we));
                if (beat_cnt < BEATS) begin
                    xfer_line[beat_cnt*WORD_W +: WORD_W] = wb_wdata;
                end
                beat_cnt++;
            end else if (!wb_cyc) begin
                in_xfer = 1'b0;
            end
            check_true(!(ic_done && dc_done), "both done outputs high together");
            // Both enables high in the first cycle after a release means a contended grant
            if ((prev_ic_done || prev_dc_done) && !ic_done && !dc_done) begin
                contended = ic_en && dc_en;
            end
            if (ic_done && !prev_ic_done) begin
                note_done(IC, ic_en);
            end
            if (dc_done && !prev_dc_done) begin
                note_done(DC, dc_en);
            end
            prev_ic_done = ic_done;
            prev_dc_done = dc_done;
        end
    end

    task automatic run_requests(input logic is_dc, input int count);
        addr_t a;
        line_t data;
        logic  we;
        int    gap;
        for (int n = 0; n < count; n++) begin
            gap = pick_gap();
            if (gap > 0) begin
                repeat (gap) @(posedge clk);
                #DRV_DLY;
            end
            a = pick_line_addr();
            we = is_dc && ($urandom % 2 == 0);
            data = random_line();
            if (is_dc) begin
                dc_addr = a;
                dc_we = we;
                dc_wdata = data;
                dc_en = 1'b1;
            end else begin
                ic_addr = a;
                ic_en = 1'b1;
            end
            do @(negedge clk); while (!(is_dc ? dc_done : ic_done));
            check_val("beat count", line_t'(BEATS), line_t'(beat_cnt));
            check_val("first o_wb_addr", line_t'(a), line_t'(xfer_base));
            check_val("o_wb_we", line_t'(we), line_t'(xfer_we));
            if (we) begin
                check_val("o_wb_data line", data, xfer_line);
                ref_mem[a] = data;
            end else begin
                check_val(is_dc ? "o_dc_data" : "o_ic_data", expected_line(a),
                          is_dc ? dc_rdata : ic_rdata);
            end
            repeat (pick_gap()) @(negedge clk);
            @(posedge clk);
            #DRV_DLY;
            if (is_dc) begin
                dc_en = 1'b0;
            end else begin
                ic_en = 1'b0;
            end
            @(negedge clk);
            check_true(is_dc ? dc_done : ic_done, "done fell in the cycle its enable fell");
            @(posedge clk);
            #DRV_DLY;
            check_true(!(is_dc ? dc_done : ic_done), "done still high a cycle after enable fell");
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        rst = 1'b1;
        ic_en = 1'b0;
        ic_addr = '0;
        dc_en = 1'b0;
        dc_we = 1'b0;
        dc_addr = '0;
        dc_wdata = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRV_DLY;
        rst = 1'b0;
        @(negedge clk);
        check_true(!wb_cyc && !wb_stb && !ic_done && !dc_done, "outputs active after reset");
        @(posedge clk);
        #DRV_DLY;
        fork
            run_requests(1'b0, NUM_IC);
            run_requests(1'b1, NUM_DC);
        join
        repeat (4) @(posedge clk);
        check_true(rr_cnt > 0, "no contended grant was observed");
        $display("Checks: %0d, errors: %0d, contended grants: %0d", check_cnt, err_cnt, rr_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the worst stall and acknowledge delay per beat
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog: requests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/wb_mem_model.sv */
// Wishbone pipelined slave with backing memory
// Random stall and random acknowledge delay with acknowledges in order

`default_nettype none

module wb_mem_model #(
    parameter int MAX_STALL    = 3,
    parameter int MAX_ACK_WAIT = 3,
    parameter int DRV_DLY      = 10
) (
    input  wire logic              i_wb_clk,
    input  wire logic              i_wb_rst,
    input  wire logic              i_wb_cyc,
    input  wire logic              i_wb_stb,
    input  wire logic              i_wb_we,
    input  wire mem_pkg::addr_t    i_wb_addr,
    input  wire mem_pkg::wb_word_t i_wb_data,
    output logic                   o_wb_ack,
    output logic                   o_wb_stall,
    output mem_pkg::wb_word_t      o_wb_data
);

    import mem_pkg::*;

    wb_word_t mem [addr_t];
    addr_t    pend_q [$];
    int       stall_run;
    int       ack_wait;
    logic     nxt_ack;
    logic     nxt_stall;
    wb_word_t nxt_data;

    // Unwritten words read back a pattern of their own address
    function automatic wb_word_t read_word(input addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a[15:0] ^ a[31:16] ^ 16'hC3A5;
    endfunction

    initial begin
        o_wb_ack   = 1'b0;
        o_wb_stall = 1'b0;
        o_wb_data  = '0;
        stall_run  = 0;
        ack_wait   = 0;
    end

    // Bus is sampled mid-cycle and outputs change just after the next rising edge
    always @(negedge i_wb_clk) begin
        nxt_ack   = 1'b0;
        nxt_stall = 1'b0;
        nxt_data  = '0;
        if (i_wb_rst) begin
            pend_q.delete();
            stall_run = 0;
            ack_wait  = 0;
        end else begin
            // Head beat is acknowledged at the coming edge
            if (o_wb_ack) begin
                void'(pend_q.pop_front());
            end
            if (i_wb_cyc && i_wb_stb && !o_wb_stall) begin
                if (i_wb_we) begin
                    mem[i_wb_addr] = i_wb_data;
                end
                pend_q.push_back(i_wb_addr);
            end
            // Stall about a third of the cycles and never more than MAX_STALL in a row
            if ((stall_run < MAX_STALL) && ($urandom % 3 == 0)) begin
                nxt_stall = 1'b1;
                stall_run++;
            end else begin
                stall_run = 0;
            end
            if (pend_q.size() > 0) begin
                if ((ack_wait < MAX_ACK_WAIT) && ($urandom % 3 == 0)) begin
                    ack_wait++;
                end else begin
                    nxt_ack  = 1'b1;
                    nxt_data = read_word(pend_q[0]);
                    ack_wait = 0;
                end
            end
        end
        @(posedge i_wb_clk);
        #DRV_DLY;
        o_wb_ack   = nxt_ack;
        o_wb_stall = nxt_stall;
        o_wb_data  = nxt_data;
    end

endmodule

`default_nettype wire

/* verilog/mem_subsys_top.sv */
// Memory subsystem top level
// Cache arbiter and Wishbone BIU joined through the CCU to BIU interface

`default_nettype none

module mem_subsys_top (
    input  wire logic                               i_wb_clk,
    input  wire logic                               i_wb_rst,

    // Instruction cache requester
    input  wire logic                               i_ic_en,
    input  wire mem_pkg::addr_t                     i_ic_addr,
    output mem_pkg::line_t                          o_ic_data,
    output logic                                    o_ic_done,

    // Data cache requester
    input  wire logic                               i_dc_en,
    input  wire logic                               i_dc_we,
    input  wire mem_pkg::addr_t                     i_dc_addr,
    input  wire mem_pkg::line_t                     i_dc_data,
    output mem_pkg::line_t                          o_dc_data,
    output logic                                    o_dc_done,

    // Wishbone master
    input  wire logic                               i_wb_ack,
    input  wire logic                               i_wb_stall,
    input  wire mem_pkg::wb_word_t                  i_wb_data,
    output logic                                    o_wb_cyc,
    output logic                                    o_wb_stb,
    output logic                                    o_wb_we,
    output logic [mem_pkg::WB_WORD_BYTES-1:0]       o_wb_sel,
    output mem_pkg::addr_t                          o_wb_addr,
    output mem_pkg::wb_word_t                       o_wb_data
);

    biu_if biu_bus ();

    // Round-robin owner of the bus interface
    ccu_arbiter u_ccu_arbiter (
        .i_wb_clk  (i_wb_clk),
        .i_wb_rst  (i_wb_rst),
        .i_ic_en   (i_ic_en),
        .i_ic_addr (i_ic_addr),
        .o_ic_data (o_ic_data),
        .o_ic_done (o_ic_done),
        .i_dc_en   (i_dc_en),
        .i_dc_we   (i_dc_we),
        .i_dc_addr (i_dc_addr),
        .i_dc_data (i_dc_data),
        .o_dc_data (o_dc_data),
        .o_dc_done (o_dc_done),
        .biu       (biu_bus.ccu)
    );

    // Line to beat conversion on the Wishbone bus
    wb_biu u_wb_biu (
        .i_wb_clk   (i_wb_clk),
        .i_wb_rst   (i_wb_rst),
        .i_wb_ack   (i_wb_ack),
        .i_wb_stall (i_wb_stall),
        .i_wb_data  (i_wb_data),
        .o_wb_cyc   (o_wb_cyc),
        .o_wb_stb   (o_wb_stb),
        .o_wb_we    (o_wb_we),
        .o_wb_sel   (o_wb_sel),
        .o_wb_addr  (o_wb_addr),
        .o_wb_data  (o_wb_data),
        .biu        (biu_bus.biu)
    );

endmodule

`default_nettype wire

/* biu/wb_biu.sv */
// Wishbone bus interface unit
// Splits a cache line into pipelined Wishbone beats and gathers the read data

`default_nettype none

module wb_biu (
    input  wire logic                               i_wb_clk,
    input  wire logic                               i_wb_rst,
    input  wire logic                               i_wb_ack,
    input  wire logic                               i_wb_stall,
    input  wire mem_pkg::wb_word_t                  i_wb_data,
    output logic                                    o_wb_cyc,
    output logic                                    o_wb_stb,
    output logic                                    o_wb_we,
    output logic [mem_pkg::WB_WORD_BYTES-1:0]       o_wb_sel,
    output mem_pkg::addr_t                          o_wb_addr,
    output mem_pkg::wb_word_t                       o_wb_data,

    biu_if.biu                                      biu
);

    import mem_pkg::*;

    localparam int CNT_WIDTH = BEAT_IDX_WIDTH + 1;
    localparam int WORD_W    = $bits(wb_word_t);

    biu_state_e                state_q;
    biu_state_e                state_d;
    logic [CNT_WIDTH-1:0]      req_cnt;
    logic [CNT_WIDTH-1:0]      ack_cnt;
    logic [BEAT_IDX_WIDTH-1:0] req_idx;
    logic [BEAT_IDX_WIDTH-1:0] ack_idx;
    addr_t                     addr_offset;
    line_t                     line_q;
    logic                      in_progress;
    logic                      accept;
    logic                      ack_seen;
    logic                      last_req;
    logic                      last_ack;

    assign in_progress = (state_q == REQS) || (state_q == ACKS);

    // Beat is taken by the slave when strobe is up and it does not stall
    assign accept   = (state_q == REQS) && !i_wb_stall;
    assign ack_seen = in_progress && i_wb_ack;
    assign last_req = accept && (req_cnt == CNT_WIDTH'(BEATS - 1));
    assign last_ack = ack_seen && (ack_cnt == CNT_WIDTH'(BEATS - 1));

    assign req_idx = req_cnt[BEAT_IDX_WIDTH-1:0];
    assign ack_idx = ack_cnt[BEAT_IDX_WIDTH-1:0];

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (biu.en) begin
                    state_d = REQS;
                end
            end
            REQS: begin
                // Leave only once the final beat has really gone out
                if (last_req) begin
                    state_d = last_ack ? DONE : ACKS;
                end
            end
            ACKS: begin
                if (last_ack) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                if (!biu.en) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Beat and acknowledge bookkeeping restarts on every idle cycle
    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst || (state_q == IDLE)) begin
            req_cnt     <= '0;
            ack_cnt     <= '0;
            addr_offset <= '0;
        end else begin
            if (accept) begin
                req_cnt     <= req_cnt + CNT_WIDTH'(1);
                addr_offset <= addr_offset + addr_t'(WB_WORD_BYTES);
            end
            if (ack_seen) begin
                ack_cnt <= ack_cnt + CNT_WIDTH'(1);
            end
        end
    end

    // Each read acknowledge fills its own word of the line
    always_ff @(posedge i_wb_clk) begin
        if (ack_seen && !biu.we) begin
            line_q[ack_idx*WORD_W +: WORD_W] <= i_wb_data;
        end
    end

    // CCU side
    assign biu.rdata = line_q;
    assign biu.busy  = in_progress;
    assign biu.done  = (state_q == DONE);

    // Wishbone side
    assign o_wb_cyc  = in_progress;
    assign o_wb_stb  = (state_q == REQS);
    assign o_wb_we   = biu.we;
    assign o_wb_sel  = '1;
    assign o_wb_addr = biu.addr + addr_offset;
    assign o_wb_data = biu.wdata[req_idx*WORD_W +: WORD_W];

endmodule

`default_nettype wire

/* ccu/ccu_arbiter.sv */
// Cache control unit arbiter
// Round-robin ownership of the BIU between instruction and data caches

`default_nettype none

module ccu_arbiter (
    input  wire logic           i_wb_clk,
    input  wire logic           i_wb_rst,

    // Instruction cache, read only
    input  wire logic           i_ic_en,
    input  wire mem_pkg::addr_t i_ic_addr,
    output mem_pkg::line_t      o_ic_data,
    output logic                o_ic_done,

    // Data cache, fill and write back
    input  wire logic           i_dc_en,
    input  wire logic           i_dc_we,
    input  wire mem_pkg::addr_t i_dc_addr,
    input  wire mem_pkg::line_t i_dc_data,
    output mem_pkg::line_t      o_dc_data,
    output logic                o_dc_done,

    biu_if.ccu                  biu
);

    import mem_pkg::*;

    ccu_owner_e owner_q;
    ccu_owner_e owner_d;
    logic       last_dc_q;
    logic       owner_ic;
    logic       owner_dc;

    assign owner_ic = (owner_q == IC);
    assign owner_dc = (owner_q == DC);

    // Pick the next owner
    // A new grant is only made once the BIU is free again
    always_comb begin
        owner_d = owner_q;
        case (owner_q)
            NONE: begin
                if (!biu.busy) begin
                    if (i_ic_en && i_dc_en) begin
                        // When both wait the one not served last wins
                        owner_d = last_dc_q ? IC : DC;
                    end else if (i_ic_en) begin
                        owner_d = IC;
                    end else if (i_dc_en) begin
                        owner_d = DC;
                    end
                end
            end
            IC: begin
                if (!i_ic_en) begin
                    owner_d = NONE;
                end
            end
            DC: begin
                if (!i_dc_en) begin
                    owner_d = NONE;
                end
            end
            default: owner_d = NONE;
        endcase
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_wb_rst) begin
            owner_q   <= NONE;
            last_dc_q <= 1'b0;
        end else begin
            owner_q <= owner_d;
            // Remember who got the last grant
            if ((owner_q == NONE) && (owner_d != NONE)) begin
                last_dc_q <= (owner_d == DC);
            end
        end
    end

    // Request to the BIU follows the owner
    assign biu.en    = (owner_ic & i_ic_en) | (owner_dc & i_dc_en);
    assign biu.we    = owner_dc & i_dc_we;
    assign biu.addr  = owner_dc ? i_dc_addr : i_ic_addr;
    assign biu.wdata = i_dc_data;

    // Results go back to the owner only
    assign o_ic_done = owner_ic & biu.done;
    assign o_dc_done = owner_dc & biu.done;
    assign o_ic_data = owner_ic ? biu.rdata : '0;
    assign o_dc_data = owner_dc ? biu.rdata : '0;

endmodule

`default_nettype wire

/* common/biu_if.sv */
// CCU to BIU line request interface
// Level request with done; en is held until done, done is held until en falls

`default_nettype none

interface biu_if;

    // Request side, driven by the CCU
    logic            en;
    logic            we;
    mem_pkg::addr_t  addr;
    mem_pkg::line_t  wdata;

    // Result side, driven by the BIU
    mem_pkg::line_t  rdata;
    logic            busy;
    logic            done;

    modport ccu (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  busy,
        input  done
    );

    modport biu (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output busy,
        output done
    );

endinterface

`default_nettype wire

/* common/mem_pkg.sv */
// Memory subsystem package
// Line, word and address types plus the BIU and CCU enumerations

`default_nettype none

`include "mem_cfg.svh"

package mem_pkg;

    typedef logic [`MEM_ADDR_WIDTH-1:0]    addr_t;
    typedef logic [`MEM_WB_DATA_WIDTH-1:0] wb_word_t;

    localparam int LINE_WIDTH     = `MEM_LINE_BYTES * 8;
    localparam int BEATS          = LINE_WIDTH / `MEM_WB_DATA_WIDTH;
    localparam int WB_WORD_BYTES  = `MEM_WB_DATA_WIDTH / 8;
    localparam int BEAT_IDX_WIDTH = $clog2(BEATS);

    typedef logic [LINE_WIDTH-1:0] line_t;

    // Bus interface unit states
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        REQS = 2'b01,
        ACKS = 2'b10,
        DONE = 2'b11
    } biu_state_e;

    // Current owner of the BIU
    typedef enum logic [1:0] {
        NONE = 2'b00,
        IC   = 2'b01,
        DC   = 2'b10
    } ccu_owner_e;

endpackage

`default_nettype wire

/* common/mem_cfg.svh */
// Memory subsystem configuration
// Address width, Wishbone bus width and cache line size

`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Byte address width
`define MEM_ADDR_WIDTH 32

// Wishbone data bus width in bits
`define MEM_WB_DATA_WIDTH 16

// Cache line size in bytes
`define MEM_LINE_BYTES 32

`endif
